/* verilog/obi_xbar_pkg.sv */
/* OBI bus types, address map and sizing for the memory subsystem.
   Address map is fixed here and end addresses are exclusive.
   Only 32-bit word accesses with byte enables are supported. */

package obi_xbar_pkg;

  // ------------------------------------------------------------
  // Bus structs
  // ------------------------------------------------------------
  // Master request, 70 bits
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // Slave response, 34 bits (no error, no back-pressure)
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  // ------------------------------------------------------------
  // Crossbar sizing and address map
  // ------------------------------------------------------------
  localparam int unsigned XBAR_NSLAVE = 2;
  localparam int unsigned SLAVE_IDX_W = 1;

  // One rule, range [start_addr, end_addr)
  typedef struct packed {
    logic [SLAVE_IDX_W-1:0] idx;
    logic [31:0]            start_addr;
    logic [31:0]            end_addr;
  } addr_rule_t;

  // Unmatched addresses land on the slow memory
  localparam logic [SLAVE_IDX_W-1:0] DEFAULT_IDX = 1'b1;

  // Slave 0 is the SRAM, slave 1 the slow memory
  localparam addr_rule_t ADDR_MAP [XBAR_NSLAVE] = '{
    '{idx: 1'b0, start_addr: 32'h0000_0000, end_addr: 32'h0000_1000},
    '{idx: 1'b1, start_addr: 32'h0001_0000, end_addr: 32'h0001_1000}
  };

  // Outstanding response tracking
  localparam int unsigned XBAR_MAX_OUTST = 4;
  localparam int unsigned OUTST_CNT_W    = $clog2(XBAR_MAX_OUTST + 1);

  // Memory depths and word index widths (index taken from addr bit 2 up)
  localparam int unsigned SRAM_WORDS = 256;
  localparam int unsigned SRAM_AW    = $clog2(SRAM_WORDS);
  localparam int unsigned SLOW_WORDS = 64;
  localparam int unsigned SLOW_AW    = $clog2(SLOW_WORDS);

endpackage

/* verilog/addr_decode.sv */
/* Address decoder over the fixed ADDR_MAP rules.
   No decode error, unmatched addresses return DEFAULT_IDX.
   Overlapping rules resolve to the highest-numbered match. */
`timescale 1ns/1ps

module addr_decode
  import obi_xbar_pkg::*;
(
  input  logic [31:0]            addr_i,
  output logic [SLAVE_IDX_W-1:0] idx_o
);

  // ------------------------------------------------------------
  // Per-rule range match
  // ------------------------------------------------------------
  logic [XBAR_NSLAVE-1:0] rule_hit;

  always_comb begin
    for (int unsigned r = 0; r < XBAR_NSLAVE; r++) begin
      // Start inclusive, end exclusive
      rule_hit[r] = (addr_i >= ADDR_MAP[r].start_addr) &&
                    (addr_i <  ADDR_MAP[r].end_addr);
    end
  end

  // ------------------------------------------------------------
  // Index select
  // ------------------------------------------------------------
  // Fallback first, later rules override earlier ones
  always_comb begin
    idx_o = DEFAULT_IDX;
    for (int unsigned r = 0; r < XBAR_NSLAVE; r++) begin
      if (rule_hit[r]) begin
        idx_o = ADDR_MAP[r].idx;
      end
    end
  end

endmodule

/* verilog/xbar_one_to_n.sv */
/* One OBI master to XBAR_NSLAVE slaves, zero added latency both ways.
   A request to another slave waits until all responses are back,
   so responses never reorder. At most XBAR_MAX_OUTST in flight. */
`timescale 1ns/1ps

module xbar_one_to_n
  import obi_xbar_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,

  // Master port
  input  obi_req_t                     master_req_i,
  output obi_resp_t                    master_resp_o,

  // Slave ports
  output obi_req_t  [XBAR_NSLAVE-1:0]  slave_req_o,
  input  obi_resp_t [XBAR_NSLAVE-1:0]  slave_resp_i
);

  // ------------------------------------------------------------
  // Internal signals
  // ------------------------------------------------------------
  logic [SLAVE_IDX_W-1:0] dec_idx;     // slave hit by current address
  logic [SLAVE_IDX_W-1:0] cur_idx_q;   // slave owning in-flight traffic
  logic [OUTST_CNT_W-1:0] outst_cnt_q;
  logic                   stall;
  logic                   fwd_req;     // req passed on to a slave
  logic                   fire;        // granted transfer
  logic                   resp_done;   // rvalid from current slave

  // Address decoder, default slave on miss
  addr_decode u_addr_decode (
    .addr_i (master_req_i.addr),
    .idx_o  (dec_idx)
  );

  // ------------------------------------------------------------
  // Request path
  // ------------------------------------------------------------
  // Hold off a switch of slave while responses are pending
  // and any request once the tracker is full
  assign stall = ((outst_cnt_q != '0) && (dec_idx != cur_idx_q)) ||
                 (outst_cnt_q == OUTST_CNT_W'(XBAR_MAX_OUTST));

  assign fwd_req = master_req_i.req && !stall;

  // Fields broadcast, req only to the decoded slave
  for (genvar s = 0; s < XBAR_NSLAVE; s++) begin : gen_slave_req
    always_comb begin
      slave_req_o[s]     = master_req_i;
      slave_req_o[s].req = fwd_req && (dec_idx == SLAVE_IDX_W'(s));
    end
  end

  // Grant comes back combinationally from the selected slave
  assign fire = fwd_req && slave_resp_i[dec_idx].gnt;

  // ------------------------------------------------------------
  // Response path
  // ------------------------------------------------------------
  // Steered from the registered owner, no added cycle
  assign resp_done = slave_resp_i[cur_idx_q].rvalid;

  always_comb begin
    master_resp_o.gnt    = fire;
    master_resp_o.rvalid = resp_done;
    master_resp_o.rdata  = slave_resp_i[cur_idx_q].rdata;
  end

  // ------------------------------------------------------------
  // Outstanding tracker
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cur_idx_q   <= '0;
      outst_cnt_q <= '0;
    end else begin
      // Owner only changes on a grant, and a grant to another
      // slave is only possible with nothing in flight
      if (fire) begin
        cur_idx_q <= dec_idx;
      end
      case ({fire, resp_done})
        2'b10:   outst_cnt_q <= outst_cnt_q + 1'b1;
        2'b01:   outst_cnt_q <= outst_cnt_q - 1'b1;
        default: outst_cnt_q <= outst_cnt_q;  // idle, or in and out together
      endcase
    end
  end

endmodule

/* verilog/obi_sram.sv */
/* Zero-wait-state OBI word memory, SRAM_WORDS deep, no reset on contents.
   Word index is addr[SRAM_AW+1:2], upper address bits are ignored.
   rvalid one cycle after each grant, for reads and writes. */
`timescale 1ns/1ps

module obi_sram
  import obi_xbar_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  obi_req_t  req_i,
  output obi_resp_t resp_o
);

  // ------------------------------------------------------------
  // Storage and response registers
  // ------------------------------------------------------------
  logic [31:0]        mem [SRAM_WORDS];
  logic [SRAM_AW-1:0] word_idx;
  logic               gnt;
  logic               rvalid_q;
  logic [31:0]        rdata_q;

  // Never stalls
  assign gnt      = req_i.req;
  assign word_idx = req_i.addr[SRAM_AW+1:2];

  // Byte-enabled write at grant
  always_ff @(posedge clk_i) begin
    if (gnt && req_i.we) begin
      for (int unsigned b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read data captured at grant, old contents on a write
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      rdata_q <= mem[word_idx];
    end
  end

  // One response per grant
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt;
    end
  end

  always_comb begin
    resp_o.gnt    = gnt;
    resp_o.rvalid = rvalid_q;
    resp_o.rdata  = rdata_q;
  end

endmodule

/* verilog/obi_slow_mem.sv */
/* Slow OBI word memory, SLOW_WORDS deep, index addr[SLOW_AW+1:2].
   Grants at most every other cycle, rvalid two cycles after grant.
   Contents are not reset. */
`timescale 1ns/1ps

module obi_slow_mem
  import obi_xbar_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  obi_req_t  req_i,
  output obi_resp_t resp_o
);

  // ------------------------------------------------------------
  // Storage, busy flag and response pipeline
  // ------------------------------------------------------------
  logic [31:0]        mem [SLOW_WORDS];
  logic [SLOW_AW-1:0] word_idx;
  logic               gnt;
  logic               busy_q;      // set the cycle after a grant
  logic               s1_valid_q;  // stage 1, one cycle after grant
  logic               s2_valid_q;  // stage 2, drives rvalid
  logic [31:0]        s1_data_q;
  logic [31:0]        s2_data_q;

  assign gnt      = req_i.req && !busy_q;
  assign word_idx = req_i.addr[SLOW_AW+1:2];

  // Write enabled bytes at grant
  always_ff @(posedge clk_i) begin
    if (gnt && req_i.we) begin
      for (int unsigned b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Data stages, sampled at grant then shifted
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      s1_data_q <= mem[word_idx];
    end
    s2_data_q <= s1_data_q;
  end

  // Control state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q     <= 1'b0;
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      busy_q     <= gnt;
      s1_valid_q <= gnt;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_comb begin
    resp_o.gnt    = gnt;
    resp_o.rvalid = s2_valid_q;
    resp_o.rdata  = s2_data_q;
  end

endmodule

/* verilog/obi_mem_sys.sv */
/* Memory subsystem top: one OBI master port, crossbar, SRAM on
   slave 0 and slow memory on slave 1. Address map in obi_xbar_pkg. */
`timescale 1ns/1ps

module obi_mem_sys
  import obi_xbar_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  obi_req_t  master_req_i,
  output obi_resp_t master_resp_o
);

  // ------------------------------------------------------------
  // Crossbar to memory wiring
  // ------------------------------------------------------------
  obi_req_t  [XBAR_NSLAVE-1:0] slave_req;
  obi_resp_t [XBAR_NSLAVE-1:0] slave_resp;

  // Request routing and response return
  xbar_one_to_n u_xbar (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .master_req_i  (master_req_i),
    .master_resp_o (master_resp_o),
    .slave_req_o   (slave_req),
    .slave_resp_i  (slave_resp)
  );

  // Slave 0, single-cycle SRAM
  obi_sram u_sram (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .req_i  (slave_req[0]),
    .resp_o (slave_resp[0])
  );

  // Slave 1, slow memory and default target
  obi_slow_mem u_slow_mem (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .req_i  (slave_req[1]),
    .resp_o (slave_resp[1])
  );

endmodule

/* verification/obi_mem_sys_tb.sv */
/* Testbench for obi_mem_sys with one behavioral OBI master and a reference memory model.
   Every word is filled before the first read, because memory contents are undefined.
   Concurrent assertions check the data, the ordering, the latency and the stall rules. */
`timescale 1ns/1ps

module obi_mem_sys_tb
  import obi_xbar_pkg::*;
;

  localparam int CLK_PERIOD  = 4;
  localparam int N_TXN       = 476;  // fill 320, decode 20, byte_en 48, latency 8, switch 80
  localparam int TIMEOUT_CYC = N_TXN * 10 + 200;
  localparam logic [31:0] DEC_ADDRS [10] = '{
    32'h0000_0000, 32'h0000_0FFC, 32'h0000_0404, 32'h0001_0000, 32'h0001_0FFC,
    32'h0001_0044, 32'h0000_1000, 32'h0000_2000, 32'h0001_2008, 32'hFFFF_FFF0
  };

  // Expected response, one per grant
  typedef struct packed {
    logic        is_read;
    logic [31:0] data;
  } exp_t;

  logic        clk_i;
  logic        rst_i;
  obi_req_t    mreq;
  obi_resp_t   master_resp_o;
  exp_t        exp_q [$];
  exp_t        head;
  logic [31:0] sram_model [SRAM_WORDS];
  logic [31:0] slow_model [SLOW_WORDS];
  integer      seed = 89852;
  int          errors = 0;
  int          outst;
  string       cur_test = "reset";
  logic        req_seen, owner_q, chk_rd, chk_orphan;
  logic        sram_fire_q, slow_fire_q, slow_fire_q2;
  logic [31:0] chk_exp, chk_act;
  logic        fire_now, tgt_now, slow_fire_now;

  obi_mem_sys UUT (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .master_req_i  (mreq),
    .master_resp_o (master_resp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Reference model helpers
  // ------------------------------------------------------------
  // SRAM range goes to slave 0, slow range and any miss to slave 1
  function automatic logic target_of(input logic [31:0] addr);
    if (addr >= 32'h0000_0000 && addr < 32'h0000_1000) return 1'b0;
    return 1'b1;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // 0 SRAM range, 1 slow range, else anywhere (mostly unmapped)
  function automatic logic [31:0] pick_addr(input logic [1:0] sel, input logic [31:0] r);
    case (sel)
      2'd0:    return {20'h0, r[11:2], 2'b00};
      2'd1:    return {16'h0001, 4'h0, r[11:2], 2'b00};
      default: return {r[31:2], 2'b00};
    endcase
  endfunction

  // Fill word mixes every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B9) ^ {addr[15:0], addr[31:16]};
  endfunction

  // ------------------------------------------------------------
  // Master driver
  // ------------------------------------------------------------
  // Fields held until the grant, caller continues on the grant edge
  task automatic issue(input logic we, input logic [31:0] addr,
                       input logic [31:0] wdata, input logic [3:0] be);
    mreq.req   <= 1'b1;
    mreq.we    <= we;
    mreq.be    <= be;
    mreq.addr  <= addr;
    mreq.wdata <= wdata;
    @(posedge clk_i);
    while (!master_resp_o.gnt) begin
      @(posedge clk_i);
    end
  endtask

  // Drop req and wait for every response and its check
  task automatic drain();
    mreq.req <= 1'b0;
    @(posedge clk_i);
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
  endtask

  // ------------------------------------------------------------
  // Monitor and scoreboard
  // ------------------------------------------------------------
  assign fire_now      = mreq.req && master_resp_o.gnt;
  assign tgt_now       = target_of(mreq.addr);
  assign slow_fire_now = fire_now && tgt_now;

  always @(posedge clk_i) begin
    if (rst_i) begin
      exp_q.delete();
      outst      <= 0;
      owner_q    <= 1'b0;
      req_seen   <= 1'b0;
      chk_rd     <= 1'b0;
      chk_orphan <= 1'b0;
      {sram_fire_q, slow_fire_q, slow_fire_q2} <= 3'b000;
    end else begin
      chk_rd     <= 1'b0;
      chk_orphan <= 1'b0;
      if (mreq.req) req_seen <= 1'b1;
      // Oldest grant is answered first
      if (master_resp_o.rvalid) begin
        if (exp_q.size() == 0) begin
          chk_orphan <= 1'b1;
        end else begin
          head    = exp_q.pop_front();
          chk_rd  <= head.is_read;
          chk_exp <= head.data;
          chk_act <= master_resp_o.rdata;
        end
      end
      if (fire_now) begin
        owner_q      <= tgt_now;
        head.is_read = !mreq.we;
        head.data    = tgt_now ? slow_model[mreq.addr[7:2]] : sram_model[mreq.addr[9:2]];
        exp_q.push_back(head);
        if (mreq.we && !tgt_now) begin
          sram_model[mreq.addr[9:2]] = merge_bytes(head.data, mreq.wdata, mreq.be);
        end else if (mreq.we) begin
          slow_model[mreq.addr[7:2]] = merge_bytes(head.data, mreq.wdata, mreq.be);
        end
      end
      outst        <= outst + (fire_now ? 1 : 0) - (master_resp_o.rvalid ? 1 : 0);
      sram_fire_q  <= fire_now && !tgt_now;
      slow_fire_q  <= slow_fire_now;
      slow_fire_q2 <= slow_fire_q;
    end
  end

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------
  idle_after_reset: assert property (@(posedge clk_i) disable iff (rst_i)
    (!req_seen && !mreq.req) |-> (!master_resp_o.gnt && !master_resp_o.rvalid))
    else begin
      errors++;
      $display("gnt or rvalid went high before any request");
    end

  read_data: assert property (@(posedge clk_i) disable iff (rst_i)
    chk_rd |-> (chk_act === chk_exp))
    else begin
      errors++;
      $display("Mismatch in %s: expected %08h, actual %08h", cur_test, chk_exp, chk_act);
    end

  no_orphan: assert property (@(posedge clk_i) disable iff (rst_i) !chk_orphan)
    else begin
      errors++;
      $display("rvalid arrived with no granted transfer waiting");
    end

  outst_limit: assert property (@(posedge clk_i) disable iff (rst_i)
    outst <= int'(XBAR_MAX_OUTST))
    else begin
      errors++;
      $display("Too many transactions outstanding: %0d", outst);
    end

  sram_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    sram_fire_q |-> master_resp_o.rvalid)
    else begin
      errors++;
      $display("Mismatch in %s: SRAM rvalid expected 1, actual 0", cur_test);
    end

  slow_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    slow_fire_q2 |-> master_resp_o.rvalid)
    else begin
      errors++;
      $display("Mismatch in %s: slow memory rvalid expected 1, actual 0", cur_test);
    end

  slow_gap: assert property (@(posedge clk_i) disable iff (rst_i)
    slow_fire_q |-> !slow_fire_now)
    else begin
      errors++;
      $display("Slow memory granted on two cycles in a row");
    end

  no_switch: assert property (@(posedge clk_i) disable iff (rst_i)
    (outst != 0 && master_resp_o.gnt) |-> (tgt_now == owner_q))
    else begin
      errors++;
      $display("Grant to another slave with responses outstanding");
    end

  // Watchdog
  initial begin
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("ERRORS FOUND");
    $finish;
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    logic [31:0] rnd;
    logic [31:0] addr;
    rst_i = 1'b1;
    mreq  = '0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (4) @(posedge clk_i);

    // Fill both memories through their own ranges
    cur_test = "fill";
    for (int i = 0; i < int'(SRAM_WORDS); i++) begin
      addr = 32'(i * 4);
      issue(1'b1, addr, fill_word(addr), 4'hF);
    end
    for (int i = 0; i < int'(SLOW_WORDS); i++) begin
      addr = 32'h0001_0000 + 32'(i * 4);
      issue(1'b1, addr, fill_word(addr), 4'hF);
    end
    drain();

    // Range edges and misses, misses alias into the slow memory
    cur_test = "decode";
    for (int i = 0; i < 10; i++) begin
      issue(1'b1, DEC_ADDRS[i], $random(seed), 4'hF);
    end
    for (int i = 0; i < 10; i++) begin
      issue(1'b0, DEC_ADDRS[i], 32'h0, 4'hF);
    end
    drain();

    cur_test = "byte_en";
    for (int i = 0; i < 24; i++) begin
      rnd  = $random(seed);
      addr = pick_addr({1'b0, rnd[0]}, rnd);
      issue(1'b1, addr, $random(seed), rnd[15:12]);
      issue(1'b0, addr, 32'h0, 4'hF);
    end
    drain();

    // Isolated transfers, fixed latency
    cur_test = "latency";
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      issue(rnd[4], pick_addr({1'b0, rnd[0]}, rnd), $random(seed), 4'hF);
      drain();
    end

    // Back-to-back traffic across both slaves and misses
    cur_test = "switch";
    for (int i = 0; i < 80; i++) begin
      rnd = $random(seed);
      issue(rnd[2], pick_addr(rnd[1:0], rnd), $random(seed), rnd[19:16]);
    end
    drain();

    $display("Run complete: %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* build.f */
verilog/obi_xbar_pkg.sv
verilog/addr_decode.sv
verilog/xbar_one_to_n.sv
verilog/obi_sram.sv
verilog/obi_slow_mem.sv
verilog/obi_mem_sys.sv
verification/obi_mem_sys_tb.sv

/* Makefile */
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= obi_mem_sys_tb
SEED      ?= 89852
LOG       ?= sim.log
BUILD     ?= obj_dir
FLIST     ?= build.f

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-f $(FLIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
